//--- Makefile
TOP = weight_buffer_tb
OBJ = obj_dir

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f project.f \
		--top-module $(TOP) -Mdir $(OBJ)

run: compile
	./$(OBJ)/V$(TOP) | tee sim.log
	grep -q "^TESTS PASSED$$" sim.log

clean:
	rm -rf $(OBJ) sim.log

//--- bench/wb_tasks.svh
`ifndef WB_TASKS_SVH
`define WB_TASKS_SVH

localparam int ACK_LIMIT = 16; // cycles to wait for an ack before giving up

// classic cycle: strobe on one edge, ack seen one cycle later, strobe dropped after it
task automatic bus_cycle(
	input logic we,
	input logic [WB_ADR_WIDTH-1:0] adr,
	input logic [WB_DATA_WIDTH-1:0] dat_w,
	output logic [WB_DATA_WIDTH-1:0] dat_r
);
	int waited;
	waited = 0;
	dat_r = '0;
	@(posedge clk);
	wb_cyc <= 1'b1;
	wb_stb <= 1'b1;
	wb_we <= we;
	wb_adr <= adr;
	wb_dat_w <= dat_w;
	@(negedge clk); // ack and data are stable away from the rising edge
	while (!wb_ack && waited < ACK_LIMIT) begin
		@(negedge clk);
		waited++;
	end
	if (wb_ack) begin
		dat_r = wb_dat_r;
	end else begin
		errors++;
		$display("ERROR: no Wishbone ack for access to register %0d", adr);
	end
	@(posedge clk);
	wb_cyc <= 1'b0;
	wb_stb <= 1'b0;
	wb_we <= 1'b0;
endtask

task automatic write_reg(input logic [WB_ADR_WIDTH-1:0] adr, input logic [WB_DATA_WIDTH-1:0] data);
	logic [WB_DATA_WIDTH-1:0] unused_rd;
	bus_cycle(1'b1, adr, data, unused_rd);
endtask

task automatic read_reg(input logic [WB_ADR_WIDTH-1:0] adr, output logic [WB_DATA_WIDTH-1:0] data);
	bus_cycle(1'b0, adr, '0, data);
endtask

`endif

//--- bench/weight_buffer_tb.sv
`timescale 1ns/1ps

module weight_buffer_tb;
	import cnn_pkg::*;

	// fill takes about 3200 cycles and each run at half throughput stays under 300
	localparam int TIMEOUT_CYCLES = 20000;
	localparam int IDLE_POLL_LIMIT = 200;
	localparam int FILL_SLICES = (WEIGHT_RAM_DEPTH + SLICE_WORDS - 1) / SLICE_WORDS;
	localparam int EXP_DEPTH = 4096;

	logic clk;
	logic reset;
	logic wb_cyc;
	logic wb_stb;
	logic wb_we;
	logic [WB_ADR_WIDTH-1:0] wb_adr;
	logic [WB_DATA_WIDTH-1:0] wb_dat_w;
	logic [WB_DATA_WIDTH-1:0] wb_dat_r;
	logic wb_ack;
	logic stream_ready = 1'b1;
	logic stream_valid;
	weight_beat_t stream_beat;

	int seed = 32'h8b2;
	int errors = 0;
	int cycles = 0;
	logic backpressure = 1'b0;

	logic [DATA_WIDTH-1:0] model [WEIGHT_RAM_DEPTH]; // what the weight RAM should hold
	logic [DATA_WIDTH-1:0] staged [SLICE_WORDS];
	weight_beat_t exp_mem [EXP_DEPTH];
	int exp_wr = 0;
	int exp_rd = 0;
	weight_beat_t exp_head;

	assign exp_head = exp_mem[exp_rd];

	weight_buffer_top i_dut (.*);

	`include "wb_tasks.svh"

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	always @(posedge clk) begin
		if (backpressure) begin
			stream_ready <= 1'($random(seed));
		end else begin
			stream_ready <= 1'b1;
		end
	end

	// pop one expected beat per transfer
	always @(posedge clk) begin
		if (!reset && stream_valid && stream_ready && exp_rd != exp_wr) begin
			exp_rd <= exp_rd + 1;
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("ERROR: simulation timed out after %0d cycles", cycles);
			$display("errors: %0d", errors);
			$display("TESTS FAILED");
			$finish;
		end
	end

	ack_single_cycle: assert property (@(posedge clk) disable iff (reset)
		wb_ack |-> $past(wb_cyc && wb_stb) && !$past(wb_ack))
	else begin
		errors++;
		$display("ERROR: wb_ack without a strobe before it or wider than one cycle");
	end

	reset_state: assert property (@(posedge clk)
		reset |=> !stream_valid && !wb_ack && !i_dut.busy)
	else begin
		errors++;
		$display("ERROR: stream_valid, wb_ack or busy high after reset");
	end

	no_extra_beat: assert property (@(posedge clk) disable iff (reset)
		stream_valid && stream_ready |-> exp_rd != exp_wr)
	else begin
		errors++;
		$display("ERROR: stream beat transferred while none was expected");
	end

	beat_value: assert property (@(posedge clk) disable iff (reset)
		stream_valid && stream_ready && exp_rd != exp_wr |-> stream_beat == exp_head)
	else begin
		errors++;
		$display("CHECK FAILED stream_beat: expected 0x%h, got 0x%h",
			$sampled(exp_head), $sampled(stream_beat));
	end

	stall_stable: assert property (@(posedge clk) disable iff (reset)
		stream_valid && !stream_ready |=> stream_valid && $stable(stream_beat))
	else begin
		errors++;
		$display("ERROR: stream beat changed or valid dropped while stalled");
	end

	task automatic check_reg(input logic [WB_ADR_WIDTH-1:0] adr, input logic [31:0] exp);
		logic [31:0] got;
		read_reg(adr, got);
		assert (got === exp) else begin
			errors++;
			$display("CHECK FAILED wb_dat_r reg %0d: expected 0x%h, got 0x%h", adr, exp, got);
		end
	endtask

	task automatic load_slice(input int base);
		logic [31:0] word;
		for (int i = 0; i < SLICE_WORDS; i++) begin
			word = $random(seed);
			staged[i] = word[DATA_WIDTH-1:0]; // only the low half is a weight
			write_reg(REG_SLICE_0 + 6'(i), word);
		end
		write_reg(REG_WRITE_ADDR, 32'(base));
		for (int i = 0; i < SLICE_WORDS; i++) begin
			model[(base + i) % WEIGHT_RAM_DEPTH] = staged[i];
		end
	endtask

	// lane k of beat i reads base+i+k*fm and conv keeps lane 0 only
	function automatic weight_beat_t expected_beat(input read_mode_t mode, input int base,
			input int fm, input int i, input int count);
		weight_beat_t beat;
		int addr;
		for (int k = 0; k < PARA_Y; k++) begin
			addr = (base + i + k * fm) % WEIGHT_RAM_DEPTH;
			if (mode == MODE_FC || k == 0) begin
				beat.lanes[k] = model[addr];
			end else begin
				beat.lanes[k] = '0;
			end
		end
		beat.last = (i == count - 1);
		return beat;
	endfunction

	task automatic start_run(input read_mode_t mode, input int base, input int count, input int fm);
		write_reg(REG_FM_SIZE, 32'(fm));
		write_reg(REG_READ_BASE, 32'(base));
		write_reg(REG_READ_COUNT, 32'(count));
		for (int i = 0; i < count; i++) begin
			exp_mem[exp_wr] = expected_beat(mode, base, fm, i, count);
			exp_wr++;
		end
		write_reg(REG_CONTROL, {30'd0, logic'(mode), 1'b1});
	endtask

	task automatic wait_idle();
		logic [31:0] status;
		int polls;
		polls = 0;
		status = 32'd1;
		while (status[0] && polls < IDLE_POLL_LIMIT) begin
			read_reg(REG_CONTROL, status);
			polls++;
		end
		if (status[0]) begin
			errors++;
			$display("ERROR: run still busy after %0d polls", polls);
		end
		assert (exp_rd == exp_wr) else begin
			errors++;
			$display("CHECK FAILED beat count: expected 0x%h, got 0x%h", exp_wr, exp_rd);
		end
	endtask

	initial begin
		int base;
		int count;
		int fm;
		reset <= 1'b1;
		wb_cyc <= 1'b0;
		wb_stb <= 1'b0;
		wb_we <= 1'b0;
		wb_adr <= '0;
		wb_dat_w <= '0;
		repeat (4) @(posedge clk);
		reset <= 1'b0;
		@(posedge clk);

		check_reg(REG_CONTROL, 32'd0);
		for (int s = 0; s < FILL_SLICES; s++) begin
			load_slice(s * SLICE_WORDS); // last slice wraps past 1023
		end
		for (int i = 0; i < SLICE_WORDS; i++) begin
			check_reg(REG_SLICE_0 + 6'(i), {16'd0, staged[i]});
		end
		write_reg(REG_FM_SIZE, 32'h0000_005a);
		write_reg(REG_READ_BASE, 32'h0000_03c7);
		write_reg(REG_READ_COUNT, 32'h0000_0215);
		check_reg(REG_FM_SIZE, 32'h0000_005a);
		check_reg(REG_READ_BASE, 32'h0000_03c7);
		check_reg(REG_READ_COUNT, 32'h0000_0215);
		write_reg(6'd40, 32'hdead_beef);
		check_reg(6'd40, 32'd0);
		check_reg(6'd63, 32'd0);

		for (int s = 0; s < 5; s++) begin
			load_slice($random(seed) & 32'h3ff);
		end
		load_slice(1012);

		// conv runs at full rate
		start_run(MODE_CONV, 1000, 50, 0);
		wait_idle();
		base = $random(seed) & 32'h3ff;
		count = 1 + ($random(seed) & 32'h3f);
		start_run(MODE_CONV, base, count, 0);
		wait_idle();

		// fc runs with strided lanes that wrap too
		fm = 1 + ($random(seed) & 32'h7f);
		start_run(MODE_FC, 1010, 30, fm);
		wait_idle();
		base = $random(seed) & 32'h3ff;
		count = 1 + ($random(seed) & 32'h3f);
		fm = 1 + ($random(seed) & 32'h7f);
		start_run(MODE_FC, base, count, fm);
		wait_idle();

		backpressure <= 1'b1;
		base = $random(seed) & 32'h3ff;
		count = 1 + ($random(seed) & 32'h3f);
		start_run(MODE_CONV, base, count, 0);
		wait_idle();
		base = $random(seed) & 32'h3ff;
		count = 1 + ($random(seed) & 32'h3f);
		fm = 1 + ($random(seed) & 32'h7f);
		start_run(MODE_FC, base, count, fm);
		wait_idle();

		// start while busy must be dropped
		start_run(MODE_FC, base, 60, fm);
		check_reg(REG_CONTROL, 32'h3);
		write_reg(REG_CONTROL, 32'h3);
		wait_idle();
		check_reg(REG_CONTROL, 32'h2);

		start_run(MODE_CONV, base, 0, 0); // empty run
		wait_idle();
		repeat (8) @(posedge clk);
		check_reg(REG_CONTROL, 32'h0);
		backpressure <= 1'b0;
		repeat (4) @(posedge clk);

		$display("errors: %0d", errors);
		if (errors == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule

//--- project.f
+incdir+bench
rtl/cnn_pkg.sv
rtl/weight_ram.sv
rtl/wb_weight_port.sv
rtl/weight_fetch.sv
rtl/weight_buffer_top.sv
bench/weight_buffer_tb.sv

//--- rtl/cnn_pkg.sv
package cnn_pkg;

	// weight store geometry
	localparam int DATA_WIDTH = 16; // one float16 pattern
	localparam int KERNEL_SIZE_MAX = 5;
	localparam int SLICE_WORDS = KERNEL_SIZE_MAX * KERNEL_SIZE_MAX;
	localparam int SLICE_IDX_WIDTH = $clog2(SLICE_WORDS);
	localparam int PARA_Y = 3; // lanes per fc beat
	localparam int WEIGHT_RAM_DEPTH = 1024;
	localparam int WEIGHT_ADDR_WIDTH = 10;
	localparam int FM_SIZE_WIDTH = 8;
	localparam int COUNT_WIDTH = 10;

	// host bus
	localparam int WB_ADR_WIDTH = 6;
	localparam int WB_DATA_WIDTH = 32;

	// word addresses, slice words occupy 0 to 24
	localparam logic [WB_ADR_WIDTH-1:0] REG_SLICE_0 = 6'd0;
	localparam logic [WB_ADR_WIDTH-1:0] REG_WRITE_ADDR = 6'd25; // write commits the slice
	localparam logic [WB_ADR_WIDTH-1:0] REG_FM_SIZE = 6'd26;
	localparam logic [WB_ADR_WIDTH-1:0] REG_READ_BASE = 6'd27;
	localparam logic [WB_ADR_WIDTH-1:0] REG_READ_COUNT = 6'd28;
	localparam logic [WB_ADR_WIDTH-1:0] REG_CONTROL = 6'd29; // bit 0 start, bit 1 mode

	typedef enum logic {
		MODE_CONV = 1'b0,
		MODE_FC = 1'b1
	} read_mode_t;

	typedef logic [DATA_WIDTH-1:0] weight_t;

	// 25 weights, word 0 in the low bits
	typedef weight_t [SLICE_WORDS-1:0] weight_slice_t;

	typedef weight_t [PARA_Y-1:0] weight_lanes_t;

	typedef struct packed {
		weight_lanes_t lanes;
		logic last; // final beat of a run
	} weight_beat_t;

	// one run as requested over the bus
	typedef struct packed {
		logic [WEIGHT_ADDR_WIDTH-1:0] base;
		logic [COUNT_WIDTH-1:0] count;
		logic [FM_SIZE_WIDTH-1:0] fm_size;
		read_mode_t mode;
	} fetch_cmd_t;

endpackage

//--- rtl/wb_weight_port.sv
`timescale 1ns/1ps

module wb_weight_port (
	input logic clk,
	input logic reset,
	input logic wb_cyc,
	input logic wb_stb,
	input logic wb_we,
	input logic [cnn_pkg::WB_ADR_WIDTH-1:0] wb_adr,
	input logic [cnn_pkg::WB_DATA_WIDTH-1:0] wb_dat_w,
	input logic busy,
	output logic [cnn_pkg::WB_DATA_WIDTH-1:0] wb_dat_r,
	output logic wb_ack,
	output logic slice_we,
	output logic [cnn_pkg::WEIGHT_ADDR_WIDTH-1:0] slice_addr,
	output cnn_pkg::weight_slice_t slice_data,
	output logic fetch_start,
	output cnn_pkg::fetch_cmd_t fetch_cmd
);
	import cnn_pkg::*;

	logic req;
	logic wr_req;
	logic is_slice;
	logic [SLICE_IDX_WIDTH-1:0] slice_idx;
	logic [WB_DATA_WIDTH-1:0] rd_word;
	logic [FM_SIZE_WIDTH-1:0] fm_size_q;
	logic [WEIGHT_ADDR_WIDTH-1:0] read_base_q;
	logic [COUNT_WIDTH-1:0] read_count_q;
	read_mode_t mode_q;

	// a strobe still high during its own ack is not a new access
	assign req = wb_cyc && wb_stb && !wb_ack;
	assign wr_req = req && wb_we;

	assign is_slice = wb_adr < REG_SLICE_0 + SLICE_WORDS;
	assign slice_idx = SLICE_IDX_WIDTH'(wb_adr - REG_SLICE_0);

	// single cycle ack plus the commit and start pulses on the same edge
	always_ff @(posedge clk) begin
		if (reset) begin
			wb_ack <= 1'b0;
			slice_we <= 1'b0;
			fetch_start <= 1'b0;
		end else begin
			wb_ack <= req;
			slice_we <= wr_req && (wb_adr == REG_WRITE_ADDR);
			fetch_start <= wr_req && (wb_adr == REG_CONTROL) && wb_dat_w[0] && !busy;
		end
	end

	// staging slice, only the low half of each bus word is kept
	always_ff @(posedge clk) begin
		if (wr_req && is_slice) begin
			slice_data[slice_idx] <= wb_dat_w[DATA_WIDTH-1:0];
		end
	end

	always_ff @(posedge clk) begin
		if (wr_req && wb_adr == REG_WRITE_ADDR) begin
			slice_addr <= wb_dat_w[WEIGHT_ADDR_WIDTH-1:0];
		end
	end

	// run configuration
	always_ff @(posedge clk) begin
		if (reset) begin
			fm_size_q <= '0;
			read_base_q <= '0;
			read_count_q <= '0;
			mode_q <= MODE_CONV;
		end else if (wr_req) begin
			case (wb_adr)
				REG_FM_SIZE: fm_size_q <= wb_dat_w[FM_SIZE_WIDTH-1:0];
				REG_READ_BASE: read_base_q <= wb_dat_w[WEIGHT_ADDR_WIDTH-1:0];
				REG_READ_COUNT: read_count_q <= wb_dat_w[COUNT_WIDTH-1:0];
				REG_CONTROL: mode_q <= read_mode_t'(wb_dat_w[1]);
				default: ;
			endcase
		end
	end

	// mode_q already holds the new mode while fetch_start is high
	assign fetch_cmd = '{
		base: read_base_q,
		count: read_count_q,
		fm_size: fm_size_q,
		mode: mode_q
	};

	always_comb begin
		rd_word = '0; // unmapped reads return zero
		if (is_slice) begin
			rd_word[DATA_WIDTH-1:0] = slice_data[slice_idx];
		end else begin
			case (wb_adr)
				REG_WRITE_ADDR: rd_word[WEIGHT_ADDR_WIDTH-1:0] = slice_addr;
				REG_FM_SIZE: rd_word[FM_SIZE_WIDTH-1:0] = fm_size_q;
				REG_READ_BASE: rd_word[WEIGHT_ADDR_WIDTH-1:0] = read_base_q;
				REG_READ_COUNT: rd_word[COUNT_WIDTH-1:0] = read_count_q;
				REG_CONTROL: begin
					rd_word[0] = busy;
					rd_word[1] = mode_q;
				end
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (req) begin
			wb_dat_r <= rd_word; // valid alongside ack
		end
	end

endmodule

//--- rtl/weight_buffer_top.sv
`timescale 1ns/1ps

module weight_buffer_top (
	input logic clk,
	input logic reset,
	input logic wb_cyc,
	input logic wb_stb,
	input logic wb_we,
	input logic [cnn_pkg::WB_ADR_WIDTH-1:0] wb_adr,
	input logic [cnn_pkg::WB_DATA_WIDTH-1:0] wb_dat_w,
	input logic stream_ready,
	output logic [cnn_pkg::WB_DATA_WIDTH-1:0] wb_dat_r,
	output logic wb_ack,
	output logic stream_valid,
	output cnn_pkg::weight_beat_t stream_beat
);
	import cnn_pkg::*;

	// slice commit path
	logic slice_we;
	logic [WEIGHT_ADDR_WIDTH-1:0] slice_addr;
	weight_slice_t slice_data;

	// run control
	logic fetch_start;
	fetch_cmd_t fetch_cmd;
	logic busy;

	// ram read port
	logic rd_en;
	read_mode_t rd_mode;
	logic [WEIGHT_ADDR_WIDTH-1:0] rd_addr;
	logic [FM_SIZE_WIDTH-1:0] fm_size;
	weight_lanes_t rd_data;

	// all three blocks share the same signal names
	wb_weight_port i_port (.*);

	weight_ram i_ram (.*);

	weight_fetch i_fetch (.*);

endmodule

//--- rtl/weight_fetch.sv
`timescale 1ns/1ps

module weight_fetch (
	input logic clk,
	input logic reset,
	input logic fetch_start,
	input cnn_pkg::fetch_cmd_t fetch_cmd,
	input cnn_pkg::weight_lanes_t rd_data,
	input logic stream_ready,
	output logic rd_en,
	output cnn_pkg::read_mode_t rd_mode,
	output logic [cnn_pkg::WEIGHT_ADDR_WIDTH-1:0] rd_addr,
	output logic [cnn_pkg::FM_SIZE_WIDTH-1:0] fm_size,
	output logic busy,
	output logic stream_valid,
	output cnn_pkg::weight_beat_t stream_beat
);
	import cnn_pkg::*;

	fetch_cmd_t cmd_q;
	fetch_cmd_t cmd_cur;
	logic [COUNT_WIDTH-1:0] issued;
	logic [COUNT_WIDTH-1:0] issued_cur;
	logic [COUNT_WIDTH-1:0] accepted;
	logic more;
	logic out_free;
	logic xfer;
	logic last_issue;
	logic pend; // rd_data holds a beat not yet in the output register
	logic pend_last;

	// the first read goes out in the start cycle itself, straight from the command
	assign cmd_cur = fetch_start ? fetch_cmd : cmd_q;
	assign issued_cur = fetch_start ? '0 : issued;

	assign more = (fetch_start || busy) && (issued_cur != cmd_cur.count);
	assign out_free = !stream_valid || stream_ready; // output empty or draining
	assign xfer = stream_valid && stream_ready;
	assign rd_en = more && out_free;

	assign rd_mode = cmd_cur.mode;
	assign fm_size = cmd_cur.fm_size;
	assign rd_addr = cmd_cur.base + WEIGHT_ADDR_WIDTH'(issued_cur);
	assign last_issue = issued_cur == cmd_cur.count - 1'b1;

	always_ff @(posedge clk) begin
		if (fetch_start) begin
			cmd_q <= fetch_cmd;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			busy <= 1'b0;
			issued <= '0;
			accepted <= '0;
			pend <= 1'b0;
			stream_valid <= 1'b0;
		end else begin
			if (fetch_start) begin
				busy <= 1'b1;
				accepted <= '0;
			end else if (busy && cmd_q.count == '0) begin
				busy <= 1'b0; // empty run ends at once
			end else if (xfer) begin
				accepted <= accepted + 1'b1;
				if (accepted == cmd_q.count - 1'b1) begin
					busy <= 1'b0;
				end
			end

			issued <= issued_cur + COUNT_WIDTH'(rd_en);
			pend <= rd_en || (pend && !out_free);

			if (pend && out_free) begin
				stream_valid <= 1'b1;
			end else if (xfer) begin
				stream_valid <= 1'b0;
			end
		end
	end

	// beat payload follows the read through both stages
	always_ff @(posedge clk) begin
		if (rd_en) begin
			pend_last <= last_issue;
		end
		if (pend && out_free) begin
			stream_beat.lanes <= rd_data;
			stream_beat.last <= pend_last;
		end
	end

endmodule

//--- rtl/weight_ram.sv
`timescale 1ns/1ps

module weight_ram (
	input logic clk,
	input logic slice_we,
	input logic [cnn_pkg::WEIGHT_ADDR_WIDTH-1:0] slice_addr,
	input cnn_pkg::weight_slice_t slice_data,
	input logic rd_en,
	input cnn_pkg::read_mode_t rd_mode,
	input logic [cnn_pkg::WEIGHT_ADDR_WIDTH-1:0] rd_addr,
	input logic [cnn_pkg::FM_SIZE_WIDTH-1:0] fm_size,
	output cnn_pkg::weight_lanes_t rd_data
);
	import cnn_pkg::*;

	logic [DATA_WIDTH-1:0] mem [WEIGHT_RAM_DEPTH];
	logic [WEIGHT_ADDR_WIDTH-1:0] wr_addr [SLICE_WORDS];
	logic [WEIGHT_ADDR_WIDTH-1:0] lane_addr [PARA_Y];

	// addresses wrap at the top of the store since depth is a power of two
	always_comb begin
		for (int i = 0; i < SLICE_WORDS; i++) begin
			wr_addr[i] = slice_addr + WEIGHT_ADDR_WIDTH'(i);
		end
	end

	always_comb begin
		for (int k = 0; k < PARA_Y; k++) begin
			lane_addr[k] = rd_addr + WEIGHT_ADDR_WIDTH'(k * fm_size); // stride by fm row
		end
	end

	// whole slice lands in a single cycle
	always_ff @(posedge clk) begin
		if (slice_we) begin
			for (int i = 0; i < SLICE_WORDS; i++) begin
				mem[wr_addr[i]] <= slice_data[i];
			end
		end
	end

	// registered read, held until the next rd_en
	always_ff @(posedge clk) begin
		if (rd_en) begin
			for (int k = 0; k < PARA_Y; k++) begin
				if (rd_mode == MODE_FC || k == 0) begin
					rd_data[k] <= mem[lane_addr[k]];
				end else begin
					rd_data[k] <= '0; // conv uses lane 0 only
				end
			end
		end
	end

endmodule
